// File: spiProtocolPkg.sv
`default_nettype none

package spiProtocolPkg;

	// one command word in, one image word out
	localparam int frameBits = 32;

	// counts bits within the current phase
	typedef logic [5:0] bitCount_t;

	typedef logic [frameBits-1:0] cmdWord_t;

	typedef enum logic [1:0] {
		rxCmd,
		loadWord,
		txWord
	} xferState_t;

endpackage

`default_nettype wire

// File: bootImagePkg.sv
`default_nettype none

package bootImagePkg;

	typedef logic [31:0] romWord_t;

	// taken from command bits [7:2]
	typedef logic [5:0] wordIndex_t;

	// image word that starts the heartbeat
	localparam romWord_t markerWord = 32'h00002137;

	localparam string imageFile = "bootImage.hex";

endpackage

`default_nettype wire

// File: spiFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module spiFrontEnd
	import spiProtocolPkg::*;
	import bootImagePkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       sck,
	input  logic       csN,
	input  logic       mosi,
	input  romWord_t   swapped,
	output logic       miso,
	output wordIndex_t wordIndex,
	output logic       fetchStrobe,
	output romWord_t   fetchedWord
);

	logic [1:0] sckSync;
	logic [1:0] csNSync;
	logic [1:0] mosiSync;
	logic sckLast;

	logic sckRise;
	logic sckFall;
	logic selected;
	logic mosiBit;

	xferState_t state;
	xferState_t nextState;
	bitCount_t bitCount;
	logic lastBit;

	cmdWord_t cmdShift;
	romWord_t txShift;

	// two flops per pin, then one more on sck for edges
	always_ff @(posedge clk) begin
		if (!rstN) begin
			sckSync <= 2'b00;
			csNSync <= 2'b11;
			mosiSync <= 2'b00;
			sckLast <= 1'b0;
		end else begin
			sckSync <= {sckSync[0], sck};
			csNSync <= {csNSync[0], csN};
			mosiSync <= {mosiSync[0], mosi};
			sckLast <= sckSync[1];
		end
	end

	assign sckRise = sckSync[1] & ~sckLast;
	assign sckFall = ~sckSync[1] & sckLast;
	assign selected = ~csNSync[1];
	assign mosiBit = mosiSync[1];
	assign lastBit = (bitCount == bitCount_t'(frameBits - 1));

	always_comb begin
		nextState = state;
		if (!selected) begin
			// deselect aborts whatever phase is running
			nextState = rxCmd;
		end else begin
			case (state)
				rxCmd: begin
					if (sckRise && lastBit) begin
						nextState = loadWord;
					end
				end
				loadWord: begin
					nextState = txWord;
				end
				txWord: begin
					if (sckRise && lastBit) begin
						nextState = rxCmd;
					end
				end
				default: begin
					nextState = rxCmd;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= rxCmd;
		end else begin
			state <= nextState;
		end
	end

	// rising edges in both phases
	always_ff @(posedge clk) begin
		if (!rstN || !selected) begin
			bitCount <= '0;
		end else if (state == loadWord) begin
			bitCount <= '0;
		end else if (sckRise) begin
			if (lastBit) begin
				bitCount <= '0;
			end else begin
				bitCount <= bitCount + bitCount_t'(1);
			end
		end
	end

	// command arrives msb first
	always_ff @(posedge clk) begin
		if (state == rxCmd && selected && sckRise) begin
			cmdShift <= {cmdShift[frameBits-2:0], mosiBit};
		end
	end

	assign wordIndex = cmdShift[7:2];

	// first fall after the load belongs to the command, so no shift
	// until the host has taken bit 31
	always_ff @(posedge clk) begin
		if (!rstN || !selected) begin
			txShift <= '1;
		end else begin
			case (state)
				loadWord: begin
					txShift <= swapped;
				end
				txWord: begin
					if (sckRise && lastBit) begin
						txShift <= '1;
					end else if (sckFall && bitCount != '0) begin
						txShift <= {txShift[frameBits-2:0], 1'b1};
					end
				end
				default: begin
					txShift <= txShift;
				end
			endcase
		end
	end

	assign miso = txShift[frameBits-1];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			fetchStrobe <= 1'b0;
		end else begin
			fetchStrobe <= (state == loadWord) && selected;
		end
	end

	always_ff @(posedge clk) begin
		if (state == loadWord) begin
			fetchedWord <= swapped;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		fetchStrobe |=> !fetchStrobe)
		else $error("fetchStrobe longer than one cycle");

	assert property (@(posedge clk) disable iff (!rstN)
		bitCount <= bitCount_t'(frameBits))
		else $error("bit count past frame length: %0d", bitCount);

endmodule

`default_nettype wire

// File: bootRom.sv
`timescale 1ns/1ps
`default_nettype none

module bootRom
	import bootImagePkg::*;
#(
	parameter int romWords = 64
) (
	input  logic       clk,
	input  wordIndex_t wordIndex,
	output romWord_t   swapped
);

	romWord_t image [romWords];
	romWord_t word;

	initial begin
		$readmemh(imageFile, image);
	end

	assign word = image[wordIndex];

	// byte order reversed for the wire
	for (genvar b = 0; b < 4; b++) begin : gSwap
		assign swapped[8*b +: 8] = word[8*(3-b) +: 8];
	end

	// index is unknown until the first command has arrived
	assert property (@(posedge clk)
		!$isunknown(wordIndex) |-> int'(wordIndex) < romWords)
		else $error("word index %0d outside image", wordIndex);

endmodule

`default_nettype wire

// File: ledHeartbeat.sv
`timescale 1ns/1ps
`default_nettype none

module ledHeartbeat
	import bootImagePkg::*;
#(
	parameter int blinkTap = 23
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     fetchStrobe,
	input  romWord_t fetchedWord,
	output logic     led
);

	typedef logic [25:0] blinkCount_t;

	// fetched words are already byte swapped
	localparam romWord_t servedMarker = {
		markerWord[7:0],
		markerWord[15:8],
		markerWord[23:16],
		markerWord[31:24]
	};

	logic armed;
	logic markerSeen;
	blinkCount_t counter;

	assign markerSeen = fetchStrobe && (fetchedWord == servedMarker);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			armed <= 1'b0;
		end else if (markerSeen) begin
			armed <= 1'b1;
		end
	end

	// free running once armed, so led period is 2**blinkTap per half
	always_ff @(posedge clk) begin
		if (!rstN) begin
			counter <= '0;
		end else if (armed) begin
			counter <= counter + blinkCount_t'(1);
		end else begin
			counter <= '0;
		end
	end

	assign led = counter[blinkTap];

endmodule

`default_nettype wire

// File: spiFlashEmu.sv
`timescale 1ns/1ps
`default_nettype none

module spiFlashEmu
	import bootImagePkg::*;
#(
	parameter int romWords = 64,
	parameter int blinkTap = 23
) (
	input  logic clk,
	input  logic rstN,
	input  logic sck,
	input  logic csN,
	input  logic mosi,
	output logic miso,
	output logic led
);

	wordIndex_t wordIndex;
	romWord_t swapped;
	logic fetchStrobe;
	romWord_t fetchedWord;

	spiFrontEnd frontEnd (
		.clk        (clk),
		.rstN       (rstN),
		.sck        (sck),
		.csN        (csN),
		.mosi       (mosi),
		.swapped    (swapped),
		.miso       (miso),
		.wordIndex  (wordIndex),
		.fetchStrobe(fetchStrobe),
		.fetchedWord(fetchedWord)
	);

	bootRom #(
		.romWords(romWords)
	) rom (
		.clk      (clk),
		.wordIndex(wordIndex),
		.swapped  (swapped)
	);

	ledHeartbeat #(
		.blinkTap(blinkTap)
	) heartbeat (
		.clk        (clk),
		.rstN       (rstN),
		.fetchStrobe(fetchStrobe),
		.fetchedWord(fetchedWord),
		.led        (led)
	);

endmodule

`default_nettype wire

// File: tbChecks.svh
task automatic checkWord(input string name, input romWord_t got, input romWord_t expected);
	if (got !== expected) begin
		$display("FAIL %s: got %h, expected %h", name, got, expected);
		stopOnError();
	end
endtask

task automatic checkLed(input logic got, input logic expected);
	if (got !== expected) begin
		$display("FAIL led: got %h, expected %h", got, expected);
		stopOnError();
	end
endtask

// keeps word 1 out unless the marker is wanted
function automatic cmdWord_t randomCommand(input logic allowMarker);
	cmdWord_t cmd;
	cmd = randomBits(frameBits);
	while (!allowMarker && cmd[7:2] == 6'd1) begin
		cmd[7:2] = wordIndex_t'(randomBits(6));
	end
	return cmd;
endfunction

// miso idles high, led is watched by the monitor
task automatic checkIdleAfterReset();
	romWord_t idle;
	idle = '0;
	for (int c = 0; c < 224; c++) begin
		@(negedge clk);
		idle = {idle[30:0], miso};
		if (c % 32 == 31) begin
			checkWord("miso idle", idle, 32'hFFFF_FFFF);
		end
	end
endtask

task automatic readWordZero();
	romWord_t resp;
	spiTransfer(32'h0300_0000, 2 * frameBits, resp);
	checkWord("miso", resp, 32'hB701_4000);
endtask

task automatic randomReads(input int count, input logic allowMarker);
	cmdWord_t cmd;
	romWord_t resp;
	for (int n = 0; n < count; n++) begin
		cmd = randomCommand(allowMarker);
		spiTransfer(cmd, 2 * frameBits, resp);
		checkWord("miso", resp, expectedResponse(cmd));
	end
endtask

// csN goes high partway through the command, then a full read follows
task automatic abortedReads(input int count);
	cmdWord_t cmd;
	romWord_t resp;
	int abortBits;
	for (int n = 0; n < count; n++) begin
		abortBits = 5 + int'(randomBits(5) % 21);
		spiTransfer(randomCommand(1'b0), abortBits, resp);
		cmd = randomCommand(1'b0);
		spiTransfer(cmd, 2 * frameBits, resp);
		checkWord("miso", resp, expectedResponse(cmd));
	end
endtask

task automatic readMarker();
	cmdWord_t cmd;
	romWord_t resp;
	cmd = randomCommand(1'b1);
	cmd[7:2] = 6'd1;
	markerRequested = 1'b1;
	spiTransfer(cmd, 2 * frameBits, resp);
	checkWord("miso", resp, expectedResponse(cmd));
	if (!ledLocked) begin
		$display("led never changed level after the marker word was read");
		stopOnError();
	end
	// a few more blink periods with the bus idle
	waitCycles(10 * ledHalfPeriod);
endtask

task automatic runAllTests();
	checkIdleAfterReset();
	readWordZero();
	randomReads(60, 1'b0);
	abortedReads(4);
	readMarker();
	randomReads(6, 1'b1);
	waitCycles(40);
endtask

// File: tbSpiFlashEmu.sv
`timescale 1ns/1ps
`default_nettype none

module tbSpiFlashEmu
	import spiProtocolPkg::*;
	import bootImagePkg::*;
();

	localparam int romWords = 64;
	localparam int blinkTap = 3;
	localparam int halfCycles = 8;
	localparam int ledHalfPeriod = 2 ** blinkTap;
	// 80 transactions of 64 sck edges at 16 clk cycles each, plus margin
	localparam int cycleLimit = 80 * 64 * 16 + 2000;

	logic clk;
	logic rstN;
	logic sck;
	logic csN;
	logic mosi;
	logic miso;
	logic led;

	romWord_t modelImage [romWords];
	logic [31:0] lfsrState;
	int cycleCount;

	// heartbeat tracking
	logic markerRequested;
	logic ledLocked;
	logic expectedLed;
	int sinceToggle;
	int startWait;

	spiFlashEmu #(
		.romWords(romWords),
		.blinkTap(blinkTap)
	) uut (
		.clk (clk),
		.rstN(rstN),
		.sck (sck),
		.csN (csN),
		.mosi(mosi),
		.miso(miso),
		.led (led)
	);

	always #2 clk = ~clk;

	task automatic stopOnError();
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	// Galois form, right shift
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = stepLfsr(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic romWord_t expectedResponse(input cmdWord_t cmd);
		romWord_t word;
		word = modelImage[cmd[7:2]];
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	// mode 0 host, edges counts rising sck edges, 64 for a full read
	task automatic spiTransfer(input cmdWord_t cmd, input int edges, output romWord_t resp);
		resp = '0;
		@(posedge clk);
		csN <= 1'b0;
		mosi <= cmd[frameBits-1];
		for (int i = 0; i < edges; i++) begin
			waitCycles(halfCycles - 1);
			// sample just before the host raises sck
			@(negedge clk);
			if (i >= frameBits) begin
				resp = {resp[30:0], miso};
			end
			@(posedge clk);
			sck <= 1'b1;
			waitCycles(halfCycles);
			sck <= 1'b0;
			if (i < frameBits - 1) begin
				mosi <= cmd[frameBits-2-i];
			end else begin
				mosi <= 1'b0;
			end
		end
		waitCycles(halfCycles);
		csN <= 1'b1;
		mosi <= 1'b0;
		waitCycles(halfCycles);
	endtask

	// led stays dark until the marker, then toggles every ledHalfPeriod
	always @(negedge clk) begin
		if (rstN) begin
			if (!markerRequested) begin
				checkLed(led, 1'b0);
			end else if (!ledLocked) begin
				if (led) begin
					ledLocked = 1'b1;
					expectedLed = 1'b1;
					sinceToggle = 0;
				end else if (startWait > 2 * frameBits * halfCycles + 100) begin
					$display("heartbeat did not start after the marker word was read");
					stopOnError();
				end else begin
					startWait++;
				end
			end else begin
				sinceToggle++;
				if (sinceToggle == ledHalfPeriod) begin
					expectedLed = ~expectedLed;
					sinceToggle = 0;
				end
				checkLed(led, expectedLed);
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			stopOnError();
		end
	end

	`include "tbChecks.svh"

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		sck = 1'b0;
		csN = 1'b1;
		mosi = 1'b0;
		lfsrState = 32'h7c86;
		cycleCount = 0;
		markerRequested = 1'b0;
		ledLocked = 1'b0;
		expectedLed = 1'b0;
		sinceToggle = 0;
		startWait = 0;
		$readmemh("bootImage.hex", modelImage);
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		runAllTests();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: bootImage.hex
// one 32-bit image word per line, hex, word 0 first
// words are stored as the core fetches them, before the byte swap on the wire
004001b7
00002137
ff010113
00112623
00812423
01010413
000017b7
80078793
00f1a023
0001a703
00100793
00f71463
0040006f
00000513
00c12083
00812403
01010113
00008067
fe010113
00112e23
00812c23
02010413
fea42623
fec42783
0007a783
00078513
01c12083
01812403
02010113
00008067
004002b7
0002a303
00130313
0062a023
ff5ff06f
00050593
00058613
00c58733
40b706b3
00d12023
00a00893
00000073
0000006f
00100513
00200593
00b50633
00c1a223
0041a683
00d60463
00000013
00000013
00000013
00000013
30047073
30405073
10500073
0000a0b7
1234c137
00000093
00000193
00000213
00000293
00000313
00000393

// File: all.f
+incdir+.
spiProtocolPkg.sv
bootImagePkg.sv
spiFrontEnd.sv
bootRom.sv
ledHeartbeat.sv
spiFlashEmu.sv
tbSpiFlashEmu.sv
